// ==== bench/quiz_ref.svh ====
// expected answer for one question, digits one per byte for base and signed
function automatic quiz_pkg::answer_t ref_answer(input quiz_pkg::question_t q);
    int         radix;
    int         val;
    logic [7:0] r;
    logic       neg;
    logic       digits;
    logic       ta;
    logic       tb;
    radix  = 10;
    val    = 0;
    r      = '0;
    neg    = 1'b0;
    digits = 1'b0;
    ta     = (q.operand_a != 8'h00);
    tb     = (q.operand_b != 8'h00);
    case (q.category)
        quiz_pkg::cat_base: begin
            digits = 1'b1;
            radix  = (q.opcode == 2'd0) ? 8 : (q.opcode == 2'd1) ? 10 : 16;
            val    = int'(q.operand_a);
        end
        quiz_pkg::cat_signed: begin
            digits = 1'b1;
            r      = (q.opcode == 2'd0) ? q.operand_a + q.operand_b
                                        : q.operand_a - q.operand_b;
            neg    = r[7];
            val    = neg ? 256 - int'(r) : int'(r);   // magnitude of the 8-bit result
        end
        quiz_pkg::cat_shift: begin
            if (q.opcode == 2'd1) begin
                r = q.operand_a;
                for (int i = 0; i < int'(q.operand_b) && i < 8; i++) begin
                    r = {r[7], r[7:1]};   // sign fill one step
                end
            end else if (q.opcode == 2'd3) begin
                r = q.operand_a >> q.operand_b;
            end else begin
                r = q.operand_a << q.operand_b;   // asl and lsl agree
            end
        end
        quiz_pkg::cat_bitwise: begin
            case (q.opcode)
                2'd0:    r = q.operand_a & q.operand_b;
                2'd1:    r = q.operand_a | q.operand_b;
                2'd2:    r = ~q.operand_a;
                default: r = q.operand_a ^ q.operand_b;
            endcase
        end
        quiz_pkg::cat_logic: begin
            case (q.opcode)
                2'd0:    r = {8{ta && tb}};
                2'd1:    r = {8{ta || tb}};
                2'd2:    r = {8{!ta}};
                default: r = {8{ta != tb}};
            endcase
        end
        default: r = '0;
    endcase
    if (digits) begin
        return {neg, 3'b000, 4'(val / (radix * radix)), 4'h0, 4'((val / radix) % radix),
                4'h0, 4'(val % radix)};
    end
    return {r, 16'h0000};
endfunction

// ==== bench/quiz_checker.sv ====
`timescale 1ns/100ps

module quiz_checker (
    input logic                   clk,
    input logic                   reset,
    input quiz_bus_pkg::apb_req_t apb_req,
    input quiz_bus_pkg::apb_rsp_t apb_rsp,
    input logic                   game_active,
    input logic                   result_valid,
    input quiz_pkg::result_t      result
);
    import quiz_pkg::*;
    import quiz_bus_pkg::*;

    `include "quiz_ref.svh"

    question_t  shadow_bank [max_questions];
    record_t    shadow_rec [max_players * max_questions];
    logic [5:0] q_count;
    logic [1:0] p_last;    // players minus one
    logic [5:0] exp_q;
    logic [1:0] exp_p;
    logic       cfg_wr;
    logic       rd_record;
    logic       last_result;
    logic       ref_correct;
    logic [9:0] rec_off;
    logic       bad_judge  = 1'b0;
    logic       bad_order  = 1'b0;
    logic       bad_last   = 1'b0;
    logic       bad_record = 1'b0;
    logic       bad_apb    = 1'b0;
    logic       bad_reset  = 1'b0;
    logic       flagged;

    assign cfg_wr      = apb_req.psel & apb_req.penable & apb_req.pwrite & !game_active;
    assign rec_off     = apb_req.paddr - addr_record_base;
    assign rd_record   = apb_req.psel & apb_req.penable & !apb_req.pwrite &
                         (apb_req.paddr >= addr_record_base) &&
                         (rec_off < 10'(max_players * max_questions));
    assign last_result = (exp_q == q_count - 6'd1) && (exp_p == p_last);
    // timeout shows as elapsed at the full limit and never counts
    assign ref_correct = (result.record.elapsed != 5'(time_limit)) &&
                         (ref_answer(shadow_bank[result.question]) == result.record.answer);
    assign flagged     = bad_judge | bad_order | bad_last | bad_record | bad_apb | bad_reset;

    ////////////////////////////////////////
    // shadow state

    always_ff @(posedge clk) begin
        if (cfg_wr && apb_req.paddr < 10'(max_questions)) begin
            shadow_bank[apb_req.paddr[5:0]] <= question_t'(apb_req.pwdata[20:0]);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            q_count <= 6'd1;
            p_last  <= 2'd0;
            exp_q   <= '0;
            exp_p   <= '0;
            for (int i = 0; i < max_players * max_questions; i++) begin
                shadow_rec[i] <= '0;
            end
        end else begin
            if (cfg_wr && apb_req.paddr == addr_settings) begin
                q_count <= apb_req.pwdata[settings_qcount_lsb +: 6];
                p_last  <= apb_req.pwdata[settings_pcount_lsb +: 2];
            end
            if (cfg_wr && apb_req.paddr == addr_start) begin
                exp_q <= '0;   // new round
                exp_p <= '0;
            end else if (result_valid) begin
                shadow_rec[int'(result.player) * max_questions + int'(result.question)] <=
                    result.record;
                if (exp_q == q_count - 6'd1) begin
                    exp_q <= '0;
                    exp_p <= exp_p + 2'd1;
                end else begin
                    exp_q <= exp_q + 6'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // assertions

    a_judge: assert property (@(posedge clk) disable iff (!reset)
        result_valid |-> result.record.correct == ref_correct)
        else begin
            bad_judge = 1'b1;
            $error("[ERROR] %0t wrong judgement for question %0d", $time, result.question);
        end

    a_order: assert property (@(posedge clk) disable iff (!reset)
        result_valid |-> (result.question == exp_q) && (result.player == exp_p))
        else begin
            bad_order = 1'b1;
            $error("[ERROR] %0t result out of order", $time);
        end

    a_last: assert property (@(posedge clk) disable iff (!reset)
        $fell(game_active) == (result_valid && last_result))
        else begin
            bad_last = 1'b1;
            $error("[ERROR] %0t game_active not falling with the last result", $time);
        end

    a_record: assert property (@(posedge clk) disable iff (!reset)
        rd_record |-> apb_rsp.prdata == 32'(shadow_rec[rec_off[7:0]]))
        else begin
            bad_record = 1'b1;
            $error("[ERROR] %0t record read mismatch at %0d", $time, apb_req.paddr);
        end

    a_apb: assert property (@(posedge clk) disable iff (!reset)
        apb_rsp.pready && !(apb_req.psel && apb_req.penable && apb_req.pwrite &&
                            apb_req.paddr == addr_start && game_active && !apb_rsp.pslverr))
        else begin
            bad_apb = 1'b1;
            $error("[ERROR] %0t pready low or start during round accepted", $time);
        end

    a_reset: assert property (@(posedge clk) !reset |-> !game_active && !result_valid)
        else begin
            bad_reset = 1'b1;
            $error("[ERROR] %0t outputs active during reset", $time);
        end

endmodule

bind quiz_top quiz_checker u_chk (
    .clk          (clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .game_active  (game_active),
    .result_valid (result_valid),
    .result       (result)
);

// ==== bench/quiz_tb.sv ====
`timescale 1ns/100ps

module quiz_tb;
    import quiz_pkg::*;
    import quiz_bus_pkg::*;

    `include "quiz_ref.svh"

    localparam int num_q       = 17;   // every category and opcode once
    localparam int entry_limit = 4 * time_limit * tick_cycles;

    logic      clk = 1'b0;
    logic      reset;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic [7:0] in;
    logic      change;
    logic      confirm;
    logic      game_active;
    logic      result_valid;
    result_t   result;
    question_t qs [num_q];

    quiz_top dut (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .in           (in),
        .change       (change),
        .confirm      (confirm),
        .game_active  (game_active),
        .result_valid (result_valid),
        .result       (result)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(negedge clk) begin
        if (dut.u_chk.flagged) begin
            stop_on_error("a checker assertion failed");
        end
    end

    ////////////////////////////////////////
    // stimulus helpers

    task automatic apb_access(input logic write, input logic [9:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic wait_result(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!result_valid) begin
            if (n == limit) begin
                stop_on_error("timed out waiting for result_valid");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_active(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (game_active != level) begin
            if (n == limit) begin
                stop_on_error("timed out waiting for game_active");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic enter_answer(input answer_t ans, input logic multi);
        if (multi) begin
            @(posedge clk);
            in     <= ans[23:16];
            change <= 1'b1;
            @(posedge clk);
            change <= 1'b0;
            @(posedge clk);
            in     <= ans[15:8];
            change <= 1'b1;
            @(posedge clk);
            change <= 1'b0;
            @(posedge clk);
            in      <= ans[7:0];   // low byte goes with confirm
            confirm <= 1'b1;
        end else begin
            @(posedge clk);
            in      <= ans[23:16];
            confirm <= 1'b1;
        end
        @(posedge clk);
        confirm <= 1'b0;
    endtask

    task automatic build_questions();
        int n;
        n = 0;
        for (int c = 1; c <= 5; c++) begin
            for (int o = 0; o < 4; o++) begin
                if ((c == 1 && o == 3) || (c == 2 && o >= 2)) begin
                    continue;   // unused opcodes
                end
                qs[n].category  = category_t'(c);
                qs[n].opcode    = 2'(o);
                qs[n].operand_a = ($urandom % 4 == 0 && c == 5) ? 8'h00 : 8'($urandom);
                qs[n].operand_b = (c == 3) ? 8'($urandom % 8) : 8'($urandom);
                n++;
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        answer_t ans;
        logic    multi;
        logic    expect_timeout;
        void'($urandom(32'hfdb4_a555));
        reset   = 1'b0;
        apb_req = '0;
        in      = '0;
        change  = 1'b0;
        confirm = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        build_questions();
        for (int i = 0; i < num_q; i++) begin
            apb_access(1'b1, addr_question_base + 10'(i), 32'(qs[i]));
        end
        apb_access(1'b1, addr_settings, 32'(num_q) | (32'd1 << settings_pcount_lsb));
        apb_access(1'b1, addr_start, 32'd1);
        wait_active(1'b1, 20);
        apb_access(1'b1, addr_start, 32'd1);   // refused during a round
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < num_q; i++) begin
                ans            = ref_answer(qs[i]);
                multi          = (qs[i].category == cat_base) ||
                                 (qs[i].category == cat_signed);
                expect_timeout = (p == 1) && (i == num_q - 1);
                if (p == 0) begin
                    enter_answer(ans, multi);
                end else if (!expect_timeout) begin
                    enter_answer(ans ^ (multi ? 24'h000001 : 24'h010000), multi);
                end
                wait_result(entry_limit);   // last one runs out the countdown
                // right answers first, then wrong ones and a timeout
                assert ((result.record.correct == (p == 0)) &&
                        (!expect_timeout || result.record.elapsed == 5'(time_limit)))
                    else stop_on_error($sformatf("[ERROR] %0t wrong result for player %0d question %0d",
                                                 $time, p, i));
            end
        end
        wait_active(1'b0, 20);
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < num_q; i++) begin
                apb_access(1'b0, addr_record_base + 10'(p * max_questions + i), 32'd0);
            end
        end
        repeat (2) @(posedge clk);
        if (dut.u_chk.flagged) begin
            stop_on_error("a checker assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== design/answer_judge.sv ====
`timescale 1ns/100ps

module answer_judge (
    input  quiz_pkg::question_t question,
    input  quiz_pkg::answer_t   answer,
    output logic                correct
);
    import quiz_pkg::*;

    answer_t    expected;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] sum;
    logic [7:0] magnitude;
    logic [7:0] byte_res;

    // hundreds, tens and ones of an unsigned byte
    function automatic logic [11:0] dec_digits(input logic [7:0] v);
        logic [7:0] h;
        logic [7:0] t;
        logic [7:0] o;
        h = v / 8'd100;
        t = (v / 8'd10) % 8'd10;
        o = v % 8'd10;
        return {h[3:0], t[3:0], o[3:0]};
    endfunction

    // one digit per byte
    function automatic answer_t spread(input logic sign, input logic [11:0] d);
        return {sign, 3'b000, d[11:8], 4'h0, d[7:4], 4'h0, d[3:0]};
    endfunction

    always_comb begin
        a         = question.operand_a;
        b         = question.operand_b;
        sum       = '0;
        magnitude = '0;
        byte_res  = '0;
        expected  = '0;
        case (question.category)
            cat_base: begin
                case (base_op_t'(question.opcode))
                    op_octal:   expected = spread(1'b0, {2'b00, a[7:6], 1'b0, a[5:3],
                                                         1'b0, a[2:0]});
                    op_decimal: expected = spread(1'b0, dec_digits(a));
                    op_hex:     expected = spread(1'b0, {4'h0, a});
                    default:    expected = '0;
                endcase
            end
            cat_signed: begin
                case (arith_op_t'(question.opcode))
                    op_add:  sum = a + b;
                    op_sub:  sum = a - b;
                    default: sum = '0;
                endcase
                magnitude = sum[7] ? -sum : sum;   // -128 gives 128
                expected  = spread(sum[7], dec_digits(magnitude));
            end
            cat_shift: begin
                case (shift_op_t'(question.opcode))
                    op_asl: byte_res = a <<< b;
                    op_asr: byte_res = $signed(a) >>> b;   // sign fill
                    op_lsl: byte_res = a << b;
                    op_lsr: byte_res = a >> b;
                endcase
                expected = {byte_res, 16'h0000};
            end
            cat_bitwise: begin
                case (bit_op_t'(question.opcode))
                    op_and: byte_res = a & b;
                    op_or:  byte_res = a | b;
                    op_not: byte_res = ~a;            // operand_b unused
                    op_xor: byte_res = a ^ b;
                endcase
                expected = {byte_res, 16'h0000};
            end
            cat_logic: begin
                case (bit_op_t'(question.opcode))
                    op_and: byte_res = {8{(a != 8'h00) && (b != 8'h00)}};
                    op_or:  byte_res = {8{(a != 8'h00) || (b != 8'h00)}};
                    op_not: byte_res = {8{a == 8'h00}};
                    op_xor: byte_res = {8{(a != 8'h00) ^ (b != 8'h00)}};
                endcase
                expected = {byte_res, 16'h0000};   // all ones means true
            end
            default: expected = '0;
        endcase
    end

    assign correct = (expected == answer);

endmodule

// ==== design/quiz_bus_pkg.sv ====
package quiz_bus_pkg;

    ////////////////////////////////////////
    // apb signals

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [9:0]  paddr;    // word address
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////
    // register map

    localparam logic [9:0] addr_question_base = 10'd0;     // question_t in bits 20:0
    localparam logic [9:0] addr_settings      = 10'd64;    // see field layout below
    localparam logic [9:0] addr_start         = 10'd65;    // any write starts a round
    localparam logic [9:0] addr_status        = 10'd66;    // bit 0 round busy
    localparam logic [9:0] addr_record_base   = 10'd256;   // player * 50 + question

    // settings word: question count in bits 5:0,
    // number of players minus one in bits 9:8
    localparam int settings_qcount_lsb = 0;
    localparam int settings_pcount_lsb = 8;

endpackage

// ==== design/quiz_pkg.sv ====
package quiz_pkg;

    ////////////////////////////////////////
    // game limits

    localparam int max_questions = 50;
    localparam int max_players   = 4;
    localparam int time_limit    = 20;   // countdown ticks per answer
    localparam int tick_cycles   = 8;    // clocks per countdown tick

    ////////////////////////////////////////
    // question encoding

    typedef enum logic [2:0] {
        cat_base    = 3'd1,
        cat_signed  = 3'd2,
        cat_shift   = 3'd3,
        cat_bitwise = 3'd4,
        cat_logic   = 3'd5
    } category_t;

    typedef logic [1:0] opcode_t;   // decoded per category

    typedef enum logic [1:0] {op_octal, op_decimal, op_hex} base_op_t;
    typedef enum logic [1:0] {op_add, op_sub} arith_op_t;
    typedef enum logic [1:0] {op_asl, op_asr, op_lsl, op_lsr} shift_op_t;
    // logic questions use the same order as land, lor, lnot, lxor
    typedef enum logic [1:0] {op_and, op_or, op_not, op_xor} bit_op_t;

    typedef struct packed {
        category_t  category;
        opcode_t    opcode;
        logic [7:0] operand_a;
        logic [7:0] operand_b;
    } question_t;

    // base and signed use sign, hundreds, tens and ones in byte low nibbles,
    // the sign in bit 23. other categories use the top byte only
    typedef logic [23:0] answer_t;

    typedef struct packed {
        logic [4:0] elapsed;   // ticks used
        answer_t    answer;
        logic       correct;
    } record_t;

    typedef struct packed {
        logic [1:0] player;
        logic [5:0] question;
        record_t    record;
    } result_t;

    typedef enum logic [1:0] {st_idle, st_entry, st_done} round_state_t;

endpackage

// ==== design/quiz_regs.sv ====
`timescale 1ns/100ps

module quiz_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  quiz_bus_pkg::apb_req_t apb_req,
    output quiz_bus_pkg::apb_rsp_t apb_rsp,
    input  logic                   round_busy,
    input  logic [5:0]             question_index,
    output quiz_pkg::question_t    question,
    output logic [5:0]             question_count,
    output logic [1:0]             player_count,
    output logic                   start,
    input  logic                   record_we,
    input  logic [7:0]             record_index,
    input  quiz_pkg::record_t      record
);
    import quiz_pkg::*;
    import quiz_bus_pkg::*;

    localparam int record_words = max_players * max_questions;

    question_t  bank [max_questions];
    record_t    records [record_words];

    logic       access;
    logic       wr;
    logic       hit_question;
    logic       hit_settings;
    logic       hit_start;
    logic       hit_status;
    logic       hit_record;
    logic       cfg_hit;
    logic       cfg_write;
    logic [9:0] rec_offset;

    ////////////////////////////////////////
    // address decode

    assign access       = apb_req.psel & apb_req.penable;
    assign wr           = access & apb_req.pwrite;
    assign rec_offset   = apb_req.paddr - addr_record_base;

    assign hit_question = apb_req.paddr < addr_question_base + 10'(max_questions);
    assign hit_settings = apb_req.paddr == addr_settings;
    assign hit_start    = apb_req.paddr == addr_start;
    assign hit_status   = apb_req.paddr == addr_status;
    assign hit_record   = (apb_req.paddr >= addr_record_base) &&
                          (rec_offset < 10'(record_words));

    assign cfg_hit      = hit_question | hit_settings | hit_start;
    assign cfg_write    = wr & cfg_hit & ~round_busy;   // locked during a round

    assign start        = cfg_write & hit_start;

    assign apb_rsp.pready  = 1'b1;   // no wait states
    assign apb_rsp.pslverr = access & (~(cfg_hit | hit_status | hit_record) |
                                       (apb_req.pwrite & round_busy & cfg_hit));

    ////////////////////////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (cfg_write && hit_question) begin
            bank[apb_req.paddr[5:0]] <= question_t'(apb_req.pwdata[20:0]);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            question_count <= 6'd1;
            player_count   <= 2'd0;
        end else if (cfg_write && hit_settings) begin
            question_count <= apb_req.pwdata[settings_qcount_lsb +: 6];
            player_count   <= apb_req.pwdata[settings_pcount_lsb +: 2];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < record_words; i++) begin
                records[i] <= '0;
            end
        end else if (record_we) begin
            records[record_index] <= record;
        end
    end

    assign question = (question_index < 6'(max_questions)) ? bank[question_index] : '0;

    ////////////////////////////////////////
    // read data

    always_comb begin
        apb_rsp.prdata = '0;
        if (hit_question) begin
            apb_rsp.prdata = 32'(bank[apb_req.paddr[5:0]]);
        end else if (hit_settings) begin
            apb_rsp.prdata[settings_qcount_lsb +: 6] = question_count;
            apb_rsp.prdata[settings_pcount_lsb +: 2] = player_count;
        end else if (hit_status) begin
            apb_rsp.prdata[0] = round_busy;
        end else if (hit_record) begin
            apb_rsp.prdata = 32'(records[rec_offset[7:0]]);
        end
    end

endmodule

// ==== design/quiz_top.sv ====
`timescale 1ns/100ps

module quiz_top (
    input  logic                   clk,
    input  logic                   reset,
    input  quiz_bus_pkg::apb_req_t apb_req,
    output quiz_bus_pkg::apb_rsp_t apb_rsp,
    input  logic [7:0]             in,
    input  logic                   change,
    input  logic                   confirm,
    output logic                   game_active,
    output logic                   result_valid,
    output quiz_pkg::result_t      result
);
    import quiz_pkg::*;

    question_t  question;
    answer_t    answer;
    logic       correct;
    logic       start;
    logic [5:0] question_index;
    logic [5:0] question_count;
    logic [1:0] player_count;
    logic       record_we;
    logic [7:0] record_index;

    quiz_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .round_busy     (game_active),
        .question_index (question_index),
        .question       (question),
        .question_count (question_count),
        .player_count   (player_count),
        .start          (start),
        .record_we      (record_we),
        .record_index   (record_index),
        .record         (result.record)
    );

    round_control u_round (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .question_count (question_count),
        .player_count   (player_count),
        .question       (question),
        .in             (in),
        .change         (change),
        .confirm        (confirm),
        .correct        (correct),
        .answer         (answer),
        .record_we      (record_we),
        .record_index   (record_index),
        .question_index (question_index),
        .game_active    (game_active),
        .result_valid   (result_valid),
        .result         (result)
    );

    answer_judge u_judge (
        .question (question),
        .answer   (answer),
        .correct  (correct)
    );

endmodule

// ==== design/round_control.sv ====
`timescale 1ns/100ps

module round_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [5:0]          question_count,
    input  logic [1:0]          player_count,
    input  quiz_pkg::question_t question,
    input  logic [7:0]          in,
    input  logic                change,
    input  logic                confirm,
    input  logic                correct,
    output quiz_pkg::answer_t   answer,
    output logic                record_we,
    output logic [7:0]          record_index,
    output logic [5:0]          question_index,
    output logic                game_active,
    output logic                result_valid,
    output quiz_pkg::result_t   result
);
    import quiz_pkg::*;

    localparam int div_w = $clog2(tick_cycles);

    round_state_t     state;
    logic [div_w-1:0] tick_div;
    logic [4:0]       countdown;
    logic [1:0]       byte_count;
    logic [1:0]       player;
    logic [7:0]       hi_byte;
    logic [7:0]       mid_byte;
    logic [7:0]       low_byte;
    logic             entry;
    logic             launch;
    logic             multi_byte;
    logic             tick;
    logic             timeout;
    logic             commit;
    logic             last_question;
    logic             last_player;
    record_t          record_next;

    ////////////////////////////////////////
    // commit decision

    assign entry         = (state == st_entry);
    assign launch        = start && !entry;
    assign multi_byte    = (question.category == cat_base) ||
                           (question.category == cat_signed);
    assign tick          = (tick_div == div_w'(tick_cycles - 1));
    assign timeout       = entry && (countdown == 5'd0);
    assign commit        = timeout ||
                           (entry && confirm && (!multi_byte || byte_count == 2'd2));
    assign low_byte      = (commit && !timeout) ? in : 8'h00;   // latched by confirm
    assign last_question = (question_index == question_count - 6'd1);
    assign last_player   = (player == player_count);

    assign answer = multi_byte ? {hi_byte, mid_byte, low_byte} : {low_byte, 16'h0000};

    assign record_next.elapsed = 5'(time_limit) - countdown;
    assign record_next.answer  = answer;
    assign record_next.correct = correct && !timeout;

    ////////////////////////////////////////
    // round sequencing

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state          <= st_idle;
            question_index <= '0;
            player         <= '0;
        end else if (launch) begin
            state          <= st_entry;
            question_index <= '0;
            player         <= '0;
        end else if (commit) begin
            if (!last_question) begin
                question_index <= question_index + 6'd1;
            end else if (!last_player) begin
                question_index <= '0;          // next player starts over
                player         <= player + 2'd1;
            end else begin
                state <= st_done;
            end
        end
    end

    ////////////////////////////////////////
    // countdown and byte entry

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tick_div   <= '0;
            countdown  <= 5'(time_limit);
            byte_count <= '0;
            hi_byte    <= '0;
            mid_byte   <= '0;
        end else if (launch || commit) begin
            tick_div   <= '0;              // fresh question
            countdown  <= 5'(time_limit);
            byte_count <= '0;
            hi_byte    <= '0;
            mid_byte   <= '0;
        end else if (entry) begin
            if (tick) begin
                tick_div  <= '0;
                countdown <= countdown - 5'd1;   // zero commits before wrapping
            end else begin
                tick_div <= tick_div + 1'b1;
            end
            if (change && multi_byte && byte_count != 2'd2) begin
                if (byte_count == 2'd0) begin
                    hi_byte <= in;
                end else begin
                    mid_byte <= in;
                end
                byte_count <= byte_count + 2'd1;
            end
        end
    end

    ////////////////////////////////////////
    // result stream

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= commit;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            result.player   <= player;
            result.question <= question_index;
            result.record   <= record_next;
            record_index    <= 8'(player) * 8'(max_questions) + 8'(question_index);
        end
    end

    assign record_we   = result_valid;   // record memory follows the stream
    assign game_active = entry;

endmodule

// ==== filelist.f ====
+incdir+bench
design/quiz_pkg.sv
design/quiz_bus_pkg.sv
design/answer_judge.sv
design/quiz_regs.sv
design/round_control.sv
design/quiz_top.sv
bench/quiz_checker.sv
bench/quiz_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the quiz testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f filelist.f --top-module quiz_tb -o quiz_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/quiz_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
